// File: design/csa_multiplier.sv
// Unsigned N x N carry-save array multiplier with final ripple add
`timescale 1ns/1ns
`default_nettype none

module csa_multiplier #(
    parameter int N = 8
) (
    input  logic [N-1:0]   multiplier,
    input  logic [N-1:0]   multiplicand,
    output logic [2*N-1:0] product
);

    // Low half comes straight out of column 0 of each row
    logic [N-1:0] low_bits;
    // Last row leftovers, summed into the high half
    logic [N-1:0] last_carry;
    logic [N-1:0] last_sum;
    logic [N-1:0] high_bits;

    genvar i, j;
    generate
        for (i = 0; i < N; i++) begin : gen_row
            for (j = 0; j < N; j++) begin : gen_col
                // Cell (i,j) weighs 2^(i+j)
                logic pp;
                logic c_in;
                logic s_in;
                logic c_out;
                logic s_out;

                if (i == 0) begin : gen_first
                    // Nothing to absorb in the top row
                    assign c_in = 1'b0;
                    assign s_in = 1'b0;
                end else begin : gen_inner
                    // Carry drops straight down, same weight one row lower
                    assign c_in = gen_row[i-1].gen_col[j].c_out;
                    if (j == N-1) begin : gen_edge
                        assign s_in = 1'b0;
                    end else begin : gen_diag
                        // Sum moves down and one column right
                        assign s_in = gen_row[i-1].gen_col[j+1].s_out;
                    end
                end

                // AND gate for the partial product bit
                assign pp    = multiplier[i] & multiplicand[j];
                // Full adder
                assign s_out = pp ^ c_in ^ s_in;
                assign c_out = (pp & c_in) | (pp & s_in) | (c_in & s_in);
            end

            assign low_bits[i] = gen_row[i].gen_col[0].s_out;
        end

        for (j = 0; j < N; j++) begin : gen_last
            assign last_carry[j] = gen_row[N-1].gen_col[j].c_out;
            if (j == N-1) begin : gen_top
                assign last_sum[j] = 1'b0;
            end else begin : gen_shift
                // Sum bit j+1 of the last row has weight 2^(N+j)
                assign last_sum[j] = gen_row[N-1].gen_col[j+1].s_out;
            end
        end
    endgenerate

    // Full product fits 2N bits so this add never carries out
    assign high_bits = last_carry + last_sum;

    assign product = {high_bits, low_bits};

endmodule

`default_nettype wire

// File: design/dot_arith_pkg.sv
// Accumulator mode type, length field ceiling, drain depth constant
`default_nettype none

package dot_arith_pkg;

    // Latched at run start by the controller
    // Obeyed by the accumulator for the whole run
    typedef enum logic {
        ACC_WRAP = 1'b0,
        ACC_SAT  = 1'b1
    } acc_mode_t;

    // Bits in the address and length fields of a command
    // Bounds the index counters, so DEPTH stays at 32 or below
    localparam int MAX_DEPTH_LOG = 6;

    // Cycles from the last issued read to done
    // Bank read, product stage, sum stage, then the done edge
    localparam int DRAIN_CYCLES = 4;

    // Width of the drain counter
    localparam int DRAIN_CNT_W = $clog2(DRAIN_CYCLES);

endpackage

`default_nettype wire

// File: design/dot_cmd_pkg.sv
// Command opcodes, load and run field layouts, packed command word
`default_nettype none

package dot_cmd_pkg;

    // Width of the load data field in the command word
    localparam int CMD_DATA_W = 16;

    // Opcode sits in cmd[31:30] for every command
    typedef enum logic [1:0] {
        OP_LOAD_A = 2'd0,
        OP_LOAD_B = 2'd1,
        OP_RUN    = 2'd2,
        OP_CLEAR  = 2'd3
    } dot_opcode_t;

    // Load view of the command word
    typedef struct packed {
        dot_opcode_t           opcode;
        logic [5:0]            addr;
        logic [7:0]            rsvd;
        // Operand taken from the low bits only
        logic [CMD_DATA_W-1:0] data;
    } dot_load_t;

    // Run and clear view of the command word
    typedef struct packed {
        dot_opcode_t opcode;
        // Vector length, 1 up to the bank depth
        logic [5:0]  len;
        // Set for a saturating sum
        logic        sat;
        logic [22:0] rsvd;
    } dot_run_t;

    // One 32-bit word, two decodings
    typedef union packed {
        dot_load_t load;
        dot_run_t  run;
    } dot_cmd_u;

endpackage

`default_nettype wire

// File: design/dot_control.sv
// Command decoder and run sequencer for the dot product engine
`timescale 1ns/1ns
`default_nettype none

module dot_control
    import dot_cmd_pkg::*;
    import dot_arith_pkg::*;
#(
    parameter  int DEPTH  = 16,
    localparam int ADDR_W = $clog2(DEPTH)
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cmd_valid,
    input  dot_cmd_u              cmd,
    output logic                  wr_en,
    output logic                  wr_sel,
    output logic [ADDR_W-1:0]     wr_addr,
    output logic [CMD_DATA_W-1:0] wr_data,
    output logic [ADDR_W-1:0]     rd_addr,
    output logic                  acc_en,
    output logic                  acc_clear,
    output acc_mode_t             acc_mode,
    output logic                  busy,
    output logic                  done,
    output logic                  cmd_err
);

    // Sequencer states
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_ISSUE = 2'd1;
    localparam logic [1:0] ST_DRAIN = 2'd2;

    // Depth in the width of the command fields
    localparam logic [MAX_DEPTH_LOG-1:0] DEPTH_LIM = MAX_DEPTH_LOG'(DEPTH);
    localparam logic [DRAIN_CNT_W-1:0]   DRAIN_END = DRAIN_CNT_W'(DRAIN_CYCLES - 1);

    logic [1:0]               state;
    // Next read index and latched vector length
    logic [MAX_DEPTH_LOG-1:0] idx;
    logic [MAX_DEPTH_LOG-1:0] run_len;
    logic [DRAIN_CNT_W-1:0]   drain_cnt;
    // High in the cycle a read address is on rd_addr
    logic                     rd_valid;

    // Decode
    dot_opcode_t op;
    logic        addr_ok;
    logic        len_ok;
    logic        accept;
    logic        do_load;
    logic        do_run;
    logic        do_clear;

    assign op      = cmd.load.opcode;
    assign addr_ok = cmd.load.addr < DEPTH_LIM;
    assign len_ok  = (cmd.run.len != '0) && (cmd.run.len <= DEPTH_LIM);

    // Nothing is taken while a run is in flight
    assign accept   = cmd_valid && !busy;
    assign do_load  = accept && (op == OP_LOAD_A || op == OP_LOAD_B) && addr_ok;
    assign do_run   = accept && (op == OP_RUN) && len_ok;
    assign do_clear = accept && (op == OP_CLEAR);

    // RUN and CLEAR zero the sum on the strobe edge itself
    assign acc_clear = do_run || do_clear;

    assign busy = (state != ST_IDLE);

    // Write payload for the bank, lands on the following edge
    always_ff @(posedge clk) begin
        if (do_load) begin
            wr_sel  <= (op == OP_LOAD_B);
            wr_addr <= cmd.load.addr[ADDR_W-1:0];
            wr_data <= cmd.load.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            idx       <= '0;
            run_len   <= '0;
            drain_cnt <= '0;
            rd_valid  <= 1'b0;
            rd_addr   <= '0;
            acc_en    <= 1'b0;
            acc_mode  <= ACC_WRAP;
            wr_en     <= 1'b0;
            done      <= 1'b0;
            cmd_err   <= 1'b0;
        end else begin
            wr_en    <= do_load;
            // Busy drops, bad opcode fields and bad lengths all flag here
            cmd_err  <= cmd_valid && !(do_load || do_run || do_clear);
            done     <= 1'b0;
            rd_valid <= 1'b0;
            // Bank data lags the address by one cycle
            acc_en   <= rd_valid;

            case (state)
                ST_IDLE: begin
                    if (do_run) begin
                        state    <= ST_ISSUE;
                        idx      <= '0;
                        run_len  <= cmd.run.len;
                        acc_mode <= cmd.run.sat ? ACC_SAT : ACC_WRAP;
                    end
                end
                ST_ISSUE: begin
                    // One read per cycle on edges 1 to L
                    rd_addr  <= idx[ADDR_W-1:0];
                    rd_valid <= 1'b1;
                    idx      <= idx + 1'b1;
                    if (idx == run_len - 1'b1) begin
                        state     <= ST_DRAIN;
                        drain_cnt <= '0;
                    end
                end
                ST_DRAIN: begin
                    // Let the last pair clear bank, product and sum stages
                    drain_cnt <= drain_cnt + 1'b1;
                    if (drain_cnt == DRAIN_END) begin
                        state <= ST_IDLE;
                        done  <= 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/dot_product_top.sv
// Dot product engine top level, controller, banks, multiplier, accumulator
`timescale 1ns/1ns
`default_nettype none

module dot_product_top
    import dot_cmd_pkg::*;
    import dot_arith_pkg::*;
#(
    parameter  int OPERAND_W = 8,
    parameter  int DEPTH     = 16,
    parameter  int ACC_W     = 24,
    localparam int ADDR_W    = $clog2(DEPTH)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cmd_valid,
    input  logic [31:0]      cmd,
    output logic             busy,
    output logic             done,
    output logic             cmd_err,
    output logic [ACC_W-1:0] result,
    output logic             overflow
);

    // Bank write port
    logic                   wr_en;
    logic                   wr_sel;
    logic [ADDR_W-1:0]      wr_addr;
    logic [CMD_DATA_W-1:0]  wr_data;

    // Read side into the multiplier
    logic [ADDR_W-1:0]      rd_addr;
    logic [OPERAND_W-1:0]   a_data;
    logic [OPERAND_W-1:0]   b_data;
    logic [2*OPERAND_W-1:0] product;

    // Accumulator control
    logic                   acc_en;
    logic                   acc_clear;
    acc_mode_t              acc_mode;

    dot_control #(
        .DEPTH (DEPTH)
    ) u_control (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .wr_en     (wr_en),
        .wr_sel    (wr_sel),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_addr   (rd_addr),
        .acc_en    (acc_en),
        .acc_clear (acc_clear),
        .acc_mode  (acc_mode),
        .busy      (busy),
        .done      (done),
        .cmd_err   (cmd_err)
    );

    // Only the low OPERAND_W bits of the data field are stored
    operand_bank #(
        .OPERAND_W (OPERAND_W),
        .DEPTH     (DEPTH)
    ) u_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_sel  (wr_sel),
        .wr_addr (wr_addr),
        .wr_data (wr_data[OPERAND_W-1:0]),
        .rd_addr (rd_addr),
        .a_data  (a_data),
        .b_data  (b_data)
    );

    csa_multiplier #(
        .N (OPERAND_W)
    ) u_mult (
        .multiplier   (a_data),
        .multiplicand (b_data),
        .product      (product)
    );

    mac_accumulator #(
        .OPERAND_W (OPERAND_W),
        .ACC_W     (ACC_W)
    ) u_acc (
        .clk       (clk),
        .rst_n     (rst_n),
        .product   (product),
        .acc_en    (acc_en),
        .acc_clear (acc_clear),
        .acc_mode  (acc_mode),
        .result    (result),
        .overflow  (overflow)
    );

endmodule

`default_nettype wire

// File: design/mac_accumulator.sv
// Product pipeline register and wrapping or saturating accumulator
`timescale 1ns/1ns
`default_nettype none

module mac_accumulator
    import dot_arith_pkg::*;
#(
    parameter  int OPERAND_W = 8,
    parameter  int ACC_W     = 24,
    localparam int PROD_W    = 2 * OPERAND_W
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [PROD_W-1:0] product,
    input  logic              acc_en,
    input  logic              acc_clear,
    input  acc_mode_t         acc_mode,
    output logic [ACC_W-1:0]  result,
    output logic              overflow
);

    // Product stage
    logic [PROD_W-1:0] prod_q;
    logic              en_q;

    // Sum with one guard bit for the carry out
    logic [ACC_W-1:0]  prod_ext;
    logic [ACC_W:0]    sum_ext;

    // Payload register, follows the multiplier every cycle
    always_ff @(posedge clk) begin
        prod_q <= product;
    end

    // Valid bit travels alongside the product
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_q <= 1'b0;
        end else begin
            en_q <= acc_en;
        end
    end

    assign prod_ext = ACC_W'(prod_q);
    assign sum_ext  = {1'b0, result} + {1'b0, prod_ext};

    // Sum stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result   <= '0;
            overflow <= 1'b0;
        end else if (acc_clear) begin
            // Clear wins over a pending add
            result   <= '0;
            overflow <= 1'b0;
        end else if (en_q) begin
            if (sum_ext[ACC_W] && acc_mode == ACC_SAT) begin
                // Clamp and stay at the top
                result   <= '1;
                overflow <= 1'b1;
            end else begin
                // Wrap mode keeps the low bits
                result <= sum_ext[ACC_W-1:0];
                // Sticky until the next clear
                if (sum_ext[ACC_W]) begin
                    overflow <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/operand_bank.sv
// Operand banks A and B with one write port and a registered dual read
`timescale 1ns/1ns
`default_nettype none

module operand_bank #(
    parameter  int OPERAND_W = 8,
    parameter  int DEPTH     = 16,
    localparam int ADDR_W    = $clog2(DEPTH)
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wr_en,
    input  logic                 wr_sel,
    input  logic [ADDR_W-1:0]    wr_addr,
    input  logic [OPERAND_W-1:0] wr_data,
    input  logic [ADDR_W-1:0]    rd_addr,
    output logic [OPERAND_W-1:0] a_data,
    output logic [OPERAND_W-1:0] b_data
);

    // Vector storage
    logic [OPERAND_W-1:0] mem_a [DEPTH];
    logic [OPERAND_W-1:0] mem_b [DEPTH];

    // Write port, wr_sel low picks A
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Banks read back as zero after reset
            for (int k = 0; k < DEPTH; k++) begin
                mem_a[k] <= '0;
                mem_b[k] <= '0;
            end
        end else if (wr_en) begin
            if (wr_sel) begin
                mem_b[wr_addr] <= wr_data;
            end else begin
                mem_a[wr_addr] <= wr_data;
            end
        end
    end

    // Both banks read at the same index every cycle
    // Data shows up one cycle after rd_addr
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_data <= '0;
            b_data <= '0;
        end else begin
            a_data <= mem_a[rd_addr];
            b_data <= mem_b[rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build the dot product engine testbench with Verilator, run it, check the outcome
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dot_product \
    --Mdir obj_dir -o sim_dot_product \
    -f sources.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/sim_dot_product)
sim_status=$?
echo "$sim_output"
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -q "^TESTS PASSED$"; then
    exit 0
else
    exit 1
fi

// File: sources.f
design/dot_arith_pkg.sv
design/dot_cmd_pkg.sv
design/csa_multiplier.sv
design/operand_bank.sv
design/mac_accumulator.sv
design/dot_control.sv
design/dot_product_top.sv
verif/tb_dot_product.sv

// File: verif/tb_dot_product.sv
// Directed testbench for the dot product engine with operand model and watchdog
`timescale 1ns/1ns
`default_nettype none

module tb_dot_product
    import dot_cmd_pkg::*;
();

    localparam int OPERAND_W = 8;
    localparam int DEPTH     = 16;
    // Narrow sum so a full run of maximum operands passes the top
    localparam int ACC_W     = 18;
    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 16;
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 200;
    // Longest wait for done after a RUN strobe
    localparam int RUN_LIMIT = DEPTH + 20;
    localparam logic [OPERAND_W-1:0] OP_MAX = '1;

    logic             clk;
    logic             rst_n;
    logic             cmd_valid;
    logic [31:0]      cmd;
    logic             busy;
    logic             done;
    logic             cmd_err;
    logic [ACC_W-1:0] result;
    logic             overflow;

    // Software copy of both banks
    logic [OPERAND_W-1:0] model_a [DEPTH];
    logic [OPERAND_W-1:0] model_b [DEPTH];

    int          pass_cnt;
    int          fail_cnt;
    int          test_errs;
    logic [31:0] rng_state;

    dot_product_top #(
        .OPERAND_W (OPERAND_W),
        .DEPTH     (DEPTH),
        .ACC_W     (ACC_W)
    ) dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .done      (done),
        .cmd_err   (cmd_err),
        .result    (result),
        .overflow  (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Ends a stuck run
    initial begin
        #((NUM_TESTS * CYCLES_PER_TEST + RESET_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired at %0t ns, the tests did not finish in time", $time);
        $display("TESTS FAILED");
        $finish;
    end

    // Xorshift32 operand source
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic dot_cmd_u load_word(input dot_opcode_t op, input int addr,
                                           input logic [15:0] data);
        dot_cmd_u w;
        w = '0;
        w.load.opcode = op;
        w.load.addr   = addr[5:0];
        w.load.data   = data;
        return w;
    endfunction

    function automatic dot_cmd_u run_word(input int len, input logic sat);
        dot_cmd_u w;
        w = '0;
        w.run.opcode = OP_RUN;
        w.run.len    = len[5:0];
        w.run.sat    = sat;
        return w;
    endfunction

    function automatic dot_cmd_u clear_word();
        dot_cmd_u w;
        w = '0;
        w.run.opcode = OP_CLEAR;
        return w;
    endfunction

    // Step to just after the next rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        assert (actual === expected) begin
            pass_cnt++;
        end else begin
            $display("[FAIL] %0t ns %s expected 0x%0h got 0x%0h",
                     $time, name, expected, actual);
            fail_cnt++;
            test_errs++;
        end
    endtask

    // One-cycle strobe, sampled on the next edge
    task automatic send_cmd(input dot_cmd_u word);
        cmd_valid = 1'b1;
        cmd       = word;
        tick();
        cmd_valid = 1'b0;
        cmd       = '0;
    endtask

    task automatic load_operand(input logic to_b, input int addr,
                                input logic [OPERAND_W-1:0] value);
        send_cmd(load_word(to_b ? OP_LOAD_B : OP_LOAD_A, addr, 16'(value)));
        if (to_b) begin
            model_b[addr] = value;
        end else begin
            model_a[addr] = value;
        end
    endtask

    // Expected sum, one product at a time, wrapped or clamped at the top
    task automatic model_dot(input int len, input logic sat,
                             output logic [ACC_W-1:0] sum, output logic ovf);
        logic [63:0] acc;
        logic [63:0] top;
        top = (64'd1 << ACC_W) - 64'd1;
        acc = '0;
        ovf = 1'b0;
        for (int k = 0; k < len; k++) begin
            acc = acc + 64'(model_a[k]) * 64'(model_b[k]);
            if (acc > top) begin
                ovf = 1'b1;
                acc = sat ? top : acc - (top + 64'd1);
            end
        end
        sum = acc[ACC_W-1:0];
    endtask

    // Counts cycles from the strobe edge, busy must hold until done
    task automatic wait_done(input int start, output int latency);
        int   cnt;
        logic seen;
        cnt  = start;
        seen = 1'b0;
        while (!seen && cnt <= RUN_LIMIT) begin
            if (done) begin
                seen = 1'b1;
            end else begin
                check_val("busy", 1, busy);
                tick();
                cnt++;
            end
        end
        assert (seen) else begin
            $display("%0t ns: no done pulse within %0d cycles of the RUN command",
                     $time, RUN_LIMIT);
            fail_cnt++;
            test_errs++;
        end
        latency = cnt;
    endtask

    task automatic run_and_check(input int len, input logic sat);
        logic [ACC_W-1:0] exp_sum;
        logic             exp_ovf;
        int               lat;
        model_dot(len, sat, exp_sum, exp_ovf);
        send_cmd(run_word(len, sat));
        wait_done(0, lat);
        check_val("done latency", len + 4, lat);
        check_val("busy", 0, busy);
        check_val("result", exp_sum, result);
        check_val("overflow", exp_ovf, overflow);
        tick();
        // Single-cycle pulse
        check_val("done", 0, done);
    endtask

    task automatic finish_test(input string name);
        $display("%s: %s, %0d errors", name, (test_errs == 0) ? "ok" : "bad", test_errs);
        test_errs = 0;
    endtask

    task automatic test_reset_state();
        check_val("busy", 0, busy);
        check_val("done", 0, done);
        check_val("cmd_err", 0, cmd_err);
        check_val("result", 0, result);
        check_val("overflow", 0, overflow);
        finish_test("reset state");
    endtask

    task automatic test_basic_dot();
        logic [31:0] r;
        for (int k = 0; k < DEPTH; k++) begin
            r = next_rand();
            load_operand(1'b0, k, r[OPERAND_W-1:0]);
            r = next_rand();
            load_operand(1'b1, k, r[OPERAND_W-1:0]);
        end
        run_and_check(DEPTH, 1'b0);
        finish_test("basic dot product");
    endtask

    task automatic test_mult_corners();
        logic [OPERAND_W-1:0] corners [3];
        corners[0] = '0;
        corners[1] = OPERAND_W'(1);
        corners[2] = OP_MAX;
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                load_operand(1'b0, 0, corners[i]);
                load_operand(1'b1, 0, corners[j]);
                run_and_check(1, 1'b0);
            end
        end
        finish_test("multiplier corners");
    endtask

    task automatic test_wrap_sat();
        for (int k = 0; k < DEPTH; k++) begin
            load_operand(1'b0, k, OP_MAX);
            load_operand(1'b1, k, OP_MAX);
        end
        // Same vectors, modulo sum first, then clamped
        run_and_check(DEPTH, 1'b0);
        run_and_check(DEPTH, 1'b1);
        finish_test("wrap versus saturate");
    endtask

    task automatic test_busy_protect();
        logic [ACC_W-1:0] exp_sum;
        logic             exp_ovf;
        int               lat;
        model_dot(DEPTH, 1'b0, exp_sum, exp_ovf);
        send_cmd(run_word(DEPTH, 1'b0));
        tick();
        // Dropped by the DUT, so the model stays as it is
        send_cmd(load_word(OP_LOAD_A, 0, 16'h0012));
        check_val("cmd_err", 1, cmd_err);
        tick();
        check_val("cmd_err", 0, cmd_err);
        wait_done(3, lat);
        check_val("done latency", DEPTH + 4, lat);
        check_val("result", exp_sum, result);
        check_val("overflow", exp_ovf, overflow);
        tick();
        // Repeat proves A[0] kept its value
        run_and_check(DEPTH, 1'b0);
        send_cmd(clear_word());
        check_val("result", 0, result);
        check_val("overflow", 0, overflow);
        check_val("cmd_err", 0, cmd_err);
        finish_test("busy protection and clear");
    endtask

    initial begin
        rng_state = 32'h7645_52c4;
        pass_cnt  = 0;
        fail_cnt  = 0;
        test_errs = 0;
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        for (int k = 0; k < DEPTH; k++) begin
            model_a[k] = '0;
            model_b[k] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        tick();

        test_reset_state();
        test_basic_dot();
        test_mult_corners();
        test_wrap_sat();
        test_busy_protect();

        $display("Summary: %0d checks passed, %0d checks failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
